// ==== build.f ====
verilog/udma_pkg.sv
verilog/udma_apb_if.sv
verilog/udma_ctrl.sv
verilog/udma_rx_channel.sv
verilog/udma_l2_arbiter.sv
verilog/udma_core.sv
verification/udma_core_props.sv
verification/udma_core_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = udma_core_tb
FILELIST = build.f

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== verification/udma_core_tb.sv ====
module udma_core_tb
    import udma_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Beats over all tests, plus some room for the register accesses
    localparam int TEST_BEATS = 10 + 8 + 12 + 8 + 48 + 16;
    localparam int WATCHDOG_CYCLES = TEST_BEATS * 20;

    logic                      sys_clk_i = 1'b0;
    logic                      rst_i = 1'b1;
    logic [APB_ADDR_WIDTH-1:0] paddr_i = '0;
    logic [31:0]               pwdata_i = '0;
    logic                      pwrite_i = 1'b0;
    logic                      psel_i = 1'b0;
    logic                      penable_i = 1'b0;
    logic [31:0]               prdata_o;
    logic                      pready_o;
    logic                      pslverr_o;
    logic [N_CH-1:0]           rx_valid_i = '0;
    logic [DATA_WIDTH-1:0]     rx_data_i [N_CH] = '{default: '0};
    datasize_e                 rx_datasize_i [N_CH] = '{default: DS_WORD};
    logic [N_CH-1:0]           rx_ready_o;
    logic [N_CH-1:0]           events_o;
    logic [N_CH-1:0]           periph_rst_o;
    logic                      l2_req_o;
    logic                      l2_gnt_i = 1'b0;
    l2_wr_t                    l2_wr_o;

    logic [15:0] lfsr_q = 16'd26183;
    logic        gnt_random = 1'b0;
    logic        gate0_closed = 1'b0;
    string       test_name = "init";
    int          wr_cnt [N_CH];
    int          ev_cnt [N_CH];
    l2_wr_t      exp_q [N_CH][$];

    udma_core dut0 (.*);

    always #5 sys_clk_i = ~sys_clk_i;

    // Fibonacci LFSR with taps 16, 14, 13, 11
    function logic rand_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    // Expected L2 write for beat k of a channel
    function automatic l2_wr_t ref_write(logic [15:0] saddr, logic [15:0] size,
                                         datasize_e ds, int k, logic cont,
                                         logic [31:0] data);
        l2_wr_t    w;
        int        bs;
        int        off;
        logic [15:0] a;
        bs = (ds == DS_BYTE) ? 1 : (ds == DS_HALF) ? 2 : 4;
        off = k * bs;
        if (cont)
            off = off % size;
        a = saddr + 16'(off);
        w.addr = 32'(a >> 2);
        if (ds == DS_BYTE)
        begin
            w.be    = 4'b0001 << a[1:0];
            w.wdata = {4{data[7:0]}};
        end
        else if (ds == DS_HALF)
        begin
            w.be    = a[1] ? 4'b1100 : 4'b0011;
            w.wdata = {2{data[15:0]}};
        end
        else
        begin
            w.be    = 4'b1111;
            w.wdata = data;
        end
        return w;
    endfunction

    task automatic fail_now(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_eq(string what, int exp, int act);
        assert (exp == act)
        else
            fail_now($sformatf("ERR %s %s expected %0h actual %0h", test_name, what, exp, act));
    endtask

    task automatic apb_access(logic wr, int slot, int reg_idx, logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge sys_clk_i);
        paddr_i   <= APB_ADDR_WIDTH'((slot << 7) | (reg_idx << 2));
        pwrite_i  <= wr;
        pwdata_i  <= wdata;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge sys_clk_i);
        penable_i <= 1'b1;
        @(negedge sys_clk_i);
        rdata = prdata_o;
        err   = pslverr_o;
        check_eq("pready", 1, pready_o);
        @(posedge sys_clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic reg_write(int slot, int reg_idx, logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, slot, reg_idx, wdata, rd, err);
    endtask

    task automatic reg_check(string what, int slot, int reg_idx, logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, slot, reg_idx, 32'h0, rd, err);
        check_eq(what, exp, rd);
    endtask

    task automatic start_ch(int c, logic [15:0] saddr, logic [15:0] size, logic cont);
        reg_write(c + 1, REG_SADDR, 32'(saddr));
        reg_write(c + 1, REG_SIZE, 32'(size));
        reg_write(c + 1, REG_CFG, {26'h0, 1'b0, cont, 3'b000, 1'b1});
    endtask

    // Pushes n beats into channel c with random gaps
    task automatic feed(int c, datasize_e ds, int n, logic [15:0] saddr,
                        logic [15:0] size, logic cont);
        logic [31:0] data;
        for (int k = 0; k < n; k++)
        begin
            data = {8'(c + 1), 8'(k), 8'(k + 8'h55), ~8'(k)};
            @(posedge sys_clk_i);
            rx_valid_i[c] <= 1'b0;
            while (rand_bit())
                @(posedge sys_clk_i);
            rx_valid_i[c]    <= 1'b1;
            rx_data_i[c]     <= data;
            rx_datasize_i[c] <= ds;
            do
                @(negedge sys_clk_i);
            while (!rx_ready_o[c]);
            exp_q[c].push_back(ref_write(saddr, size, ds, k, cont, data));
        end
        @(posedge sys_clk_i);
        rx_valid_i[c] <= 1'b0;
    endtask

    task automatic wait_writes(int c, int n);
        int t;
        t = 0;
        while (wr_cnt[c] < n)
        begin
            @(negedge sys_clk_i);
            t++;
            if (t > 1000)
                fail_now($sformatf("Timeout in %s waiting for writes of channel %0d",
                                   test_name, c));
        end
        // The event follows the last grant by one cycle
        repeat (3) @(posedge sys_clk_i);
    endtask

    task automatic clear_counts();
        for (int c = 0; c < N_CH; c++)
        begin
            wr_cnt[c] = 0;
            ev_cnt[c] = 0;
        end
    endtask

    always @(posedge sys_clk_i)
        l2_gnt_i <= gnt_random ? rand_bit() : 1'b1;

    ////////////////////////////////////////////////////////////////////
    // Comparator
    ////////////////////////////////////////////////////////////////////

    always @(negedge sys_clk_i)
    begin
        int     own;
        l2_wr_t exp;
        if (!rst_i)
        begin
            assert (!(gate0_closed && rx_ready_o[0]))
            else
                fail_now("Gated channel 0 raised rx_ready");
            for (int c = 0; c < N_CH; c++)
                if (events_o[c])
                    ev_cnt[c]++;
            if (l2_req_o && l2_gnt_i)
            begin
                own = int'(l2_wr_o.addr[13:10]) - 1;
                assert (own >= 0 && own < N_CH && exp_q[own].size() != 0)
                else
                    fail_now($sformatf("Unexpected L2 write to word address %0h",
                                       l2_wr_o.addr));
                exp = exp_q[own].pop_front();
                assert (l2_wr_o == exp)
                else
                    fail_now($sformatf("ERR %s expected %h actual %h",
                                       test_name, exp, l2_wr_o));
                wr_cnt[own]++;
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk_i);
        fail_now("Watchdog expired before the tests finished");
    end

    initial
    begin
        logic [31:0] rd;
        logic        err;
        clear_counts();
        repeat (2) @(posedge sys_clk_i);
        rst_i <= 1'b0;

        test_name = "registers";
        reg_write(2, REG_SADDR, 32'h1234);
        reg_write(2, REG_SIZE, 32'h0040);
        reg_check("saddr", 2, REG_SADDR, 32'h1234);
        reg_check("size", 2, REG_SIZE, 32'h0040);
        reg_write(0, REG_RST, 32'hA);
        reg_check("rst", 0, REG_RST, 32'hA);
        check_eq("periph_rst", 4'hA, periph_rst_o);
        reg_write(0, REG_RST, 32'h0);
        apb_access(1'b0, N_CH + 1, 0, 32'h0, rd, err);
        assert (err)
        else
            fail_now("No PSLVERR on an access to an unused slot");

        test_name = "word";
        clear_counts();
        start_ch(0, 16'h1000, 16'd32, 1'b0);
        feed(0, DS_WORD, 8, 16'h1000, 16'd32, 1'b0);
        wait_writes(0, 8);
        reg_check("curr", 1, REG_CURR, 32'h1020);
        check_eq("events", 1, ev_cnt[0]);
        reg_check("left", 1, REG_LEFT, 32'h0);
        reg_check("busy", 1, REG_CFG, 32'h0);

        test_name = "byte_half";
        clear_counts();
        start_ch(1, 16'h2001, 16'd6, 1'b0);
        feed(1, DS_BYTE, 6, 16'h2001, 16'd6, 1'b0);
        start_ch(2, 16'h3002, 16'd12, 1'b0);
        feed(2, DS_HALF, 6, 16'h3002, 16'd12, 1'b0);
        wait_writes(1, 6);
        wait_writes(2, 6);
        check_eq("events byte", 1, ev_cnt[1]);
        check_eq("events half", 1, ev_cnt[2]);

        test_name = "continuous";
        clear_counts();
        start_ch(3, 16'h4000, 16'd16, 1'b1);
        feed(3, DS_WORD, 8, 16'h4000, 16'd16, 1'b1);
        wait_writes(3, 8);
        check_eq("events", 2, ev_cnt[3]);
        reg_write(4, REG_CFG, 32'h20);

        test_name = "all_channels";
        clear_counts();
        gnt_random <= 1'b1;
        start_ch(0, 16'h1000, 16'd48, 1'b0);
        start_ch(1, 16'h2000, 16'd24, 1'b0);
        start_ch(2, 16'h3000, 16'd12, 1'b0);
        start_ch(3, 16'h4000, 16'd48, 1'b0);
        fork
            feed(0, DS_WORD, 12, 16'h1000, 16'd48, 1'b0);
            feed(1, DS_HALF, 12, 16'h2000, 16'd24, 1'b0);
            feed(2, DS_BYTE, 12, 16'h3000, 16'd12, 1'b0);
            feed(3, DS_WORD, 12, 16'h4000, 16'd48, 1'b0);
        join
        for (int c = 0; c < N_CH; c++)
        begin
            wait_writes(c, 12);
            check_eq("events", 1, ev_cnt[c]);
        end

        test_name = "gating";
        clear_counts();
        start_ch(0, 16'h1000, 16'd32, 1'b0);
        start_ch(1, 16'h2000, 16'd32, 1'b0);
        reg_write(0, REG_CG, 32'hE);
        @(posedge sys_clk_i);
        gate0_closed = 1'b1;
        rx_valid_i[0] <= 1'b1;
        feed(1, DS_WORD, 8, 16'h2000, 16'd32, 1'b0);
        wait_writes(1, 8);
        reg_check("gated left", 1, REG_LEFT, 32'd32);
        @(posedge sys_clk_i);
        rx_valid_i[0] <= 1'b0;
        gate0_closed = 1'b0;
        reg_write(0, REG_CG, 32'hF);
        feed(0, DS_WORD, 8, 16'h1000, 16'd32, 1'b0);
        wait_writes(0, 8);
        check_eq("events", 1, ev_cnt[0]);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== verification/udma_core_props.sv ====
module udma_core_props
    import udma_pkg::*;
(
    input  logic            sys_clk_i,
    input  logic            rst_i,
    input  logic            l2_req_i,
    input  logic            l2_gnt_i,
    input  l2_wr_t          l2_wr_i,
    input  logic [N_CH-1:0] events_i,
    input  logic [N_CH-1:0] rx_ready_i,
    input  logic [N_CH-1:0] gate_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // A waiting L2 request holds still until its grant
    a_l2_stable: assert property (@(posedge sys_clk_i) disable iff (rst_i)
        l2_req_i && !l2_gnt_i |=> l2_req_i && $stable(l2_wr_i))
        else $error("L2 request changed while waiting for grant");

    for (genvar i = 0; i < N_CH; i++)
    begin : g_ch
        a_event_pulse: assert property (@(posedge sys_clk_i) disable iff (rst_i)
            events_i[i] |=> !events_i[i])
            else $error("Event pulse longer than one cycle");

        a_gate_ready: assert property (@(posedge sys_clk_i) disable iff (rst_i)
            !gate_i[i] |-> !rx_ready_i[i])
            else $error("Ready high on a gated channel");
    end

endmodule

bind udma_core udma_core_props u_props (
    .sys_clk_i  ( sys_clk_i  ),
    .rst_i      ( rst_i      ),
    .l2_req_i   ( l2_req_o   ),
    .l2_gnt_i   ( l2_gnt_i   ),
    .l2_wr_i    ( l2_wr_o    ),
    .events_i   ( events_o   ),
    .rx_ready_i ( rx_ready_o ),
    .gate_i     ( s_gate     )
);

// ==== verilog/udma_core.sv ====
module udma_core
    import udma_pkg::*;
(
    input  logic                      sys_clk_i,
    input  logic                      rst_i,

    input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [31:0]               pwdata_i,
    input  logic                      pwrite_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,

    input  logic [N_CH-1:0]           rx_valid_i,
    input  logic [DATA_WIDTH-1:0]     rx_data_i [N_CH],
    input  datasize_e                 rx_datasize_i [N_CH],
    output logic [N_CH-1:0]           rx_ready_o,
    output logic [N_CH-1:0]           events_o,
    output logic [N_CH-1:0]           periph_rst_o,

    output logic                      l2_req_o,
    input  logic                      l2_gnt_i,
    output l2_wr_t                    l2_wr_o
);

    cfg_req_t        s_req;
    logic [31:0]     s_rdata;
    ch_cfg_t         s_cfg [N_CH];
    logic [N_CH-1:0] s_gate;
    ch_status_t      s_status [N_CH];
    logic [N_CH-1:0] s_beat_valid;
    l2_beat_t        s_beat [N_CH];
    logic [N_CH-1:0] s_beat_gnt;

    udma_apb_if u_apb_if (
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .pwrite_i  ( pwrite_i  ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .req_o     ( s_req     ),
        .rdata_i   ( s_rdata   )
    );

    udma_ctrl u_udma_ctrl (
        .sys_clk_i    ( sys_clk_i    ),
        .rst_i        ( rst_i        ),
        .req_i        ( s_req        ),
        .rdata_o      ( s_rdata      ),
        .cfg_o        ( s_cfg        ),
        .gate_o       ( s_gate       ),
        .status_i     ( s_status     ),
        .periph_rst_o ( periph_rst_o )
    );

    for (genvar i = 0; i < N_CH; i++)
    begin : g_rx_ch
        udma_rx_channel u_rx_channel (
            .sys_clk_i     ( sys_clk_i        ),
            .rst_i         ( rst_i            ),
            .cfg_i         ( s_cfg[i]         ),
            .gate_i        ( s_gate[i]        ),
            .status_o      ( s_status[i]      ),
            .rx_valid_i    ( rx_valid_i[i]    ),
            .rx_data_i     ( rx_data_i[i]     ),
            .rx_datasize_i ( rx_datasize_i[i] ),
            .rx_ready_o    ( rx_ready_o[i]    ),
            .beat_valid_o  ( s_beat_valid[i]  ),
            .beat_o        ( s_beat[i]        ),
            .beat_gnt_i    ( s_beat_gnt[i]    ),
            .event_o       ( events_o[i]      )
        );
    end

    udma_l2_arbiter u_l2_arbiter (
        .sys_clk_i    ( sys_clk_i    ),
        .rst_i        ( rst_i        ),
        .beat_valid_i ( s_beat_valid ),
        .beat_i       ( s_beat       ),
        .beat_gnt_o   ( s_beat_gnt   ),
        .l2_req_o     ( l2_req_o     ),
        .l2_gnt_i     ( l2_gnt_i     ),
        .l2_wr_o      ( l2_wr_o      )
    );

endmodule

// ==== verilog/udma_l2_arbiter.sv ====
module udma_l2_arbiter
    import udma_pkg::*;
(
    input  logic            sys_clk_i,
    input  logic            rst_i,

    input  logic [N_CH-1:0] beat_valid_i,
    input  l2_beat_t        beat_i [N_CH],
    output logic [N_CH-1:0] beat_gnt_o,

    output logic            l2_req_o,
    input  logic            l2_gnt_i,
    output l2_wr_t          l2_wr_o
);

    logic [CH_IDX_W-1:0] rr_q;
    logic [CH_IDX_W-1:0] sel_q;
    logic                lock_q;
    logic [CH_IDX_W-1:0] pick;
    logic [CH_IDX_W-1:0] sel;
    logic                done;
    l2_beat_t            beat;

    // First valid channel at or after the round-robin pointer
    always_comb
    begin
        logic found;
        int   idx;
        found = 1'b0;
        pick  = rr_q;
        for (int k = 0; k < N_CH; k++)
        begin
            idx = (int'(rr_q) + k) % N_CH;
            if (!found && beat_valid_i[idx])
            begin
                pick  = CH_IDX_W'(idx);
                found = 1'b1;
            end
        end
    end

    assign sel      = lock_q ? sel_q : pick;
    assign l2_req_o = lock_q | (|beat_valid_i);
    assign done     = l2_req_o & l2_gnt_i;

    always_ff @(posedge sys_clk_i)
    begin
        if (rst_i)
        begin
            rr_q   <= '0;
            lock_q <= 1'b0;
        end
        else if (done)
        begin
            lock_q <= 1'b0;
            rr_q   <= (sel == CH_IDX_W'(N_CH - 1)) ? '0 : sel + 1'b1;
        end
        else if (l2_req_o && !lock_q)
            lock_q <= 1'b1;
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (l2_req_o && !lock_q)
            sel_q <= pick;
    end

    always_comb
    begin
        beat_gnt_o      = '0;
        beat_gnt_o[sel] = done;
    end

    //////////////////////////////////////////////////////////////////////
    // Lane steering
    //////////////////////////////////////////////////////////////////////

    assign beat         = beat_i[sel];
    assign l2_wr_o.addr = 32'(beat.addr[L2_AWIDTH_NOAL-1:2]);

    always_comb
    begin
        case (beat.datasize)
            DS_BYTE:
            begin
                l2_wr_o.be    = BE_W'(4'b0001) << beat.addr[1:0];
                l2_wr_o.wdata = {4{beat.data[7:0]}};
            end
            DS_HALF:
            begin
                l2_wr_o.be    = BE_W'(4'b0011) << {beat.addr[1], 1'b0};
                l2_wr_o.wdata = {2{beat.data[15:0]}};
            end
            default:
            begin
                l2_wr_o.be    = '1;
                l2_wr_o.wdata = beat.data;
            end
        endcase
    end

endmodule

// ==== verilog/udma_rx_channel.sv ====
module udma_rx_channel
    import udma_pkg::*;
(
    input  logic                  sys_clk_i,
    input  logic                  rst_i,

    input  ch_cfg_t               cfg_i,
    input  logic                  gate_i,
    output ch_status_t            status_o,

    input  logic                  rx_valid_i,
    input  logic [DATA_WIDTH-1:0] rx_data_i,
    input  datasize_e             rx_datasize_i,
    output logic                  rx_ready_o,

    output logic                  beat_valid_o,
    output l2_beat_t              beat_o,
    input  logic                  beat_gnt_i,

    output logic                  event_o
);

    logic                      busy_q;
    logic                      buf_valid_q;
    logic                      last_q;
    logic                      event_q;
    logic [L2_AWIDTH_NOAL-1:0] curr_addr_q;
    logic [TRANS_SIZE-1:0]     bytes_left_q;
    l2_beat_t                  beat_q;

    logic [TRANS_SIZE-1:0]     nbytes;
    logic                      accept;
    logic                      is_last;

    always_comb
    begin
        case (rx_datasize_i)
            DS_BYTE: nbytes = TRANS_SIZE'(1);
            DS_HALF: nbytes = TRANS_SIZE'(2);
            default: nbytes = TRANS_SIZE'(4);
        endcase
    end

    // A closed gate freezes the channel towards both the peripheral and L2
    assign rx_ready_o = busy_q & ~buf_valid_q & gate_i;
    assign accept     = rx_valid_i & rx_ready_o;
    assign is_last    = (bytes_left_q <= nbytes);

    always_ff @(posedge sys_clk_i)
    begin
        if (rst_i)
        begin
            busy_q       <= 1'b0;
            buf_valid_q  <= 1'b0;
            last_q       <= 1'b0;
            event_q      <= 1'b0;
            curr_addr_q  <= '0;
            bytes_left_q <= '0;
        end
        else
        begin
            event_q <= 1'b0;
            if (cfg_i.clr)
            begin
                busy_q       <= 1'b0;
                buf_valid_q  <= 1'b0;
                last_q       <= 1'b0;
                bytes_left_q <= '0;
            end
            else if (cfg_i.start)
            begin
                busy_q       <= 1'b1;
                curr_addr_q  <= cfg_i.startaddr;
                bytes_left_q <= cfg_i.size;
            end
            else if (accept)
            begin
                buf_valid_q  <= 1'b1;
                last_q       <= is_last;
                curr_addr_q  <= curr_addr_q + L2_AWIDTH_NOAL'(nbytes);
                bytes_left_q <= is_last ? '0 : bytes_left_q - nbytes;
            end
            else if (beat_gnt_i && buf_valid_q)
            begin
                buf_valid_q <= 1'b0;
                if (last_q)
                begin
                    last_q  <= 1'b0;
                    event_q <= 1'b1;
                    if (cfg_i.continuous)
                    begin
                        curr_addr_q  <= cfg_i.startaddr;
                        bytes_left_q <= cfg_i.size;
                    end
                    else
                        busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge sys_clk_i)
    begin
        if (accept)
        begin
            beat_q.addr     <= curr_addr_q;
            beat_q.datasize <= rx_datasize_i;
            beat_q.data     <= rx_data_i;
        end
    end

    assign beat_valid_o = buf_valid_q & gate_i;
    assign beat_o       = beat_q;
    assign event_o      = event_q;

    assign status_o.curr_addr  = curr_addr_q;
    assign status_o.bytes_left = bytes_left_q;
    assign status_o.busy       = busy_q;

endmodule

// ==== verilog/udma_ctrl.sv ====
module udma_ctrl
    import udma_pkg::*;
(
    input  logic             sys_clk_i,
    input  logic             rst_i,

    input  cfg_req_t         req_i,
    output logic [31:0]      rdata_o,

    output ch_cfg_t          cfg_o [N_CH],
    output logic [N_CH-1:0]  gate_o,
    input  ch_status_t       status_i [N_CH],
    output logic [N_CH-1:0]  periph_rst_o
);

    logic [L2_AWIDTH_NOAL-1:0] saddr_q [N_CH];
    logic [TRANS_SIZE-1:0]     size_q [N_CH];
    logic [N_CH-1:0]           cont_q;
    logic [N_CH-1:0]           start_q;
    logic [N_CH-1:0]           clr_q;
    logic [N_CH-1:0]           cg_q;
    logic [N_CH-1:0]           rst_q;

    logic                      glob_hit;
    logic [N_CH-1:0]           ch_hit;
    logic                      wr_en;

    assign glob_hit = (req_i.slot == '0);
    assign wr_en    = req_i.valid & req_i.write;

    always_comb
    begin
        for (int i = 0; i < N_CH; i++)
            ch_hit[i] = (req_i.slot == SLOT_W'(i + 1));
    end

    //////////////////////////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk_i)
    begin
        if (rst_i)
        begin
            cont_q  <= '0;
            start_q <= '0;
            clr_q   <= '0;
            cg_q    <= '1;
            rst_q   <= '0;
            for (int i = 0; i < N_CH; i++)
            begin
                saddr_q[i] <= '0;
                size_q[i]  <= '0;
            end
        end
        else
        begin
            // Start and clear live for a single cycle
            start_q <= '0;
            clr_q   <= '0;
            if (wr_en && glob_hit)
            begin
                case (req_i.reg_addr)
                    REG_CG:  cg_q  <= req_i.wdata[N_CH-1:0];
                    REG_RST: rst_q <= req_i.wdata[N_CH-1:0];
                    default: ;
                endcase
            end
            for (int i = 0; i < N_CH; i++)
            begin
                if (wr_en && ch_hit[i])
                begin
                    case (req_i.reg_addr)
                        REG_SADDR: saddr_q[i] <= req_i.wdata[L2_AWIDTH_NOAL-1:0];
                        REG_SIZE:  size_q[i]  <= req_i.wdata[TRANS_SIZE-1:0];
                        REG_CFG:
                        begin
                            cont_q[i]  <= req_i.wdata[CFG_CONT_BIT];
                            start_q[i] <= req_i.wdata[CFG_EN_BIT];
                            clr_q[i]   <= req_i.wdata[CFG_CLR_BIT];
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        rdata_o = '0;
        if (glob_hit)
        begin
            case (req_i.reg_addr)
                REG_CG:  rdata_o[N_CH-1:0] = cg_q;
                REG_RST: rdata_o[N_CH-1:0] = rst_q;
                default: rdata_o = '0;
            endcase
        end
        for (int i = 0; i < N_CH; i++)
        begin
            if (ch_hit[i])
            begin
                case (req_i.reg_addr)
                    REG_SADDR: rdata_o[L2_AWIDTH_NOAL-1:0] = saddr_q[i];
                    REG_SIZE:  rdata_o[TRANS_SIZE-1:0]     = size_q[i];
                    REG_CFG:
                    begin
                        // The enable bit reads back as busy
                        rdata_o[CFG_EN_BIT]   = status_i[i].busy;
                        rdata_o[CFG_CONT_BIT] = cont_q[i];
                    end
                    REG_CURR:  rdata_o[L2_AWIDTH_NOAL-1:0] = status_i[i].curr_addr;
                    REG_LEFT:  rdata_o[TRANS_SIZE-1:0]     = status_i[i].bytes_left;
                    default:   rdata_o = '0;
                endcase
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < N_CH; i++)
        begin
            cfg_o[i].startaddr  = saddr_q[i];
            cfg_o[i].size       = size_q[i];
            cfg_o[i].continuous = cont_q[i];
            cfg_o[i].start      = start_q[i];
            cfg_o[i].clr        = clr_q[i];
        end
    end

    assign gate_o       = cg_q;
    assign periph_rst_o = rst_q;

endmodule

// ==== verilog/udma_apb_if.sv ====
module udma_apb_if
    import udma_pkg::*;
(
    input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [31:0]               pwdata_i,
    input  logic                      pwrite_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    output logic [31:0]               prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,

    output cfg_req_t                  req_o,
    input  logic [31:0]               rdata_i
);

    logic              access;
    logic              bad_slot;
    logic [SLOT_W-1:0] slot;
    logic [REG_W-1:0]  reg_addr;

    //////////////////////////////////////////////////////////////////////
    // Address split
    //////////////////////////////////////////////////////////////////////

    assign slot     = paddr_i[APB_ADDR_WIDTH-1 -: SLOT_W];
    assign reg_addr = paddr_i[APB_ADDR_WIDTH-SLOT_W-1 -: REG_W];

    // Only the access phase reaches the register file
    assign access   = psel_i & penable_i;
    assign bad_slot = (slot > SLOT_W'(N_CH));

    assign req_o.valid    = access & ~bad_slot;
    assign req_o.write    = pwrite_i;
    assign req_o.slot     = slot;
    assign req_o.reg_addr = reg_addr;
    assign req_o.wdata    = pwdata_i;

    //////////////////////////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////////////////////////

    assign prdata_o  = bad_slot ? 32'h0 : rdata_i;
    assign pready_o  = 1'b1;
    assign pslverr_o = access & bad_slot;

endmodule

// ==== verilog/udma_pkg.sv ====
package udma_pkg;

    localparam int N_CH           = 4;
    localparam int CH_IDX_W       = $clog2(N_CH);
    localparam int L2_AWIDTH_NOAL = 16;
    localparam int TRANS_SIZE     = 16;
    localparam int DATA_WIDTH     = 32;
    localparam int BE_W           = DATA_WIDTH / 8;
    localparam int APB_ADDR_WIDTH = 12;
    localparam int SLOT_W         = 5;
    localparam int REG_W          = 5;

    // Bit positions inside the channel CFG register
    localparam int CFG_EN_BIT   = 0;
    localparam int CFG_CONT_BIT = 4;
    localparam int CFG_CLR_BIT  = 5;

    typedef enum logic [1:0] {
        DS_BYTE = 2'd0,
        DS_HALF = 2'd1,
        DS_WORD = 2'd2
    } datasize_e;

    typedef enum logic [REG_W-1:0] {
        REG_SADDR = 5'd0,
        REG_SIZE  = 5'd1,
        REG_CFG   = 5'd2,
        REG_CURR  = 5'd3,
        REG_LEFT  = 5'd4
    } ch_reg_e;

    typedef enum logic [REG_W-1:0] {
        REG_CG  = 5'd0,
        REG_RST = 5'd1
    } glob_reg_e;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [SLOT_W-1:0]     slot;
        logic [REG_W-1:0]      reg_addr;
        logic [31:0]           wdata;
    } cfg_req_t;

    typedef struct packed {
        logic [L2_AWIDTH_NOAL-1:0] startaddr;
        logic [TRANS_SIZE-1:0]     size;
        logic                      continuous;
        logic                      start;
        logic                      clr;
    } ch_cfg_t;

    typedef struct packed {
        logic [L2_AWIDTH_NOAL-1:0] curr_addr;
        logic [TRANS_SIZE-1:0]     bytes_left;
        logic                      busy;
    } ch_status_t;

    typedef struct packed {
        logic [L2_AWIDTH_NOAL-1:0] addr;
        datasize_e                 datasize;
        logic [DATA_WIDTH-1:0]     data;
    } l2_beat_t;

    // Word address towards L2, the byte offset is carried by be
    typedef struct packed {
        logic [31:0]           addr;
        logic [BE_W-1:0]       be;
        logic [DATA_WIDTH-1:0] wdata;
    } l2_wr_t;

endpackage
